// ==== logic/id_pkg.sv ====
`default_nettype none

package id_pkg;

  // Datapath and instruction width
  localparam int XLEN       = 32;
  // Architectural register address width
  localparam int REG_ADDR_W = 5;

  // Major opcodes in instruction bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // ALU operations seen by the EX stage
  typedef enum logic [3:0] {
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    ALU_SLL  = 4'h2,
    ALU_SLT  = 4'h3,
    ALU_SLTU = 4'h4,
    ALU_XOR  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    ALU_OR   = 4'h8,
    ALU_AND  = 4'h9
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {
    OP_A_REG  = 2'b00,
    OP_A_PC   = 2'b01,
    OP_A_ZERO = 2'b10
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  // Immediate format
  typedef enum logic [1:0] {
    IMM_I = 2'b00,
    IMM_S = 2'b01,
    IMM_U = 2'b10
  } imm_sel_e;

  // LSU access size, LSU encoding
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } data_type_e;

endpackage

`default_nettype wire

// ==== logic/id_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_decoder import id_pkg::*; #(
  parameter int RV32E = 0
) (
  input  logic [XLEN-1:0] instr_i,
  output alu_op_e         alu_operator_o,
  output op_a_sel_e       op_a_sel_o,
  output op_b_sel_e       op_b_sel_o,
  output imm_sel_e        imm_sel_o,
  output logic            regfile_we_o,
  output logic            rs1_used_o,
  output logic            rs2_used_o,
  output logic            data_req_o,
  output logic            data_we_o,
  output data_type_e      data_type_o,
  output logic            data_sign_ext_o,
  output logic            illegal_insn_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Raw decode, before illegal masking
  logic       illegal_enc;
  logic       illegal_reg;
  logic       we_dec;
  logic       req_dec;
  logic       dwe_dec;
  logic       rs1_used_dec;
  logic       rs2_used_dec;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  //////////////////////////////////////////////////////////////////////
  // Opcode and function field decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_operator_o  = ALU_ADD;
    op_a_sel_o      = OP_A_REG;
    op_b_sel_o      = OP_B_REG;
    imm_sel_o       = IMM_I;
    we_dec          = 1'b0;
    req_dec         = 1'b0;
    dwe_dec         = 1'b0;
    rs1_used_dec    = 1'b0;
    rs2_used_dec    = 1'b0;
    data_type_o     = DT_WORD;
    data_sign_ext_o = 1'b0;
    illegal_enc     = 1'b0;

    case (opcode)
      // Register-register ALU
      OPC_OP: begin
        we_dec       = 1'b1;
        rs1_used_dec = 1'b1;
        rs2_used_dec = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_operator_o = ALU_ADD;
          {7'h20, 3'b000}: alu_operator_o = ALU_SUB;
          {7'h00, 3'b001}: alu_operator_o = ALU_SLL;
          {7'h00, 3'b010}: alu_operator_o = ALU_SLT;
          {7'h00, 3'b011}: alu_operator_o = ALU_SLTU;
          {7'h00, 3'b100}: alu_operator_o = ALU_XOR;
          {7'h00, 3'b101}: alu_operator_o = ALU_SRL;
          {7'h20, 3'b101}: alu_operator_o = ALU_SRA;
          {7'h00, 3'b110}: alu_operator_o = ALU_OR;
          {7'h00, 3'b111}: alu_operator_o = ALU_AND;
          default:         illegal_enc    = 1'b1;
        endcase
      end

      // Register-immediate ALU
      OPC_OP_IMM: begin
        we_dec       = 1'b1;
        rs1_used_dec = 1'b1;
        op_b_sel_o   = OP_B_IMM;
        case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          // Shifts also constrain the upper immediate bits
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_enc    = (funct7 != 7'h00);
          end
          default: begin
            if (funct7 == 7'h00) begin
              alu_operator_o = ALU_SRL;
            end else if (funct7 == 7'h20) begin
              alu_operator_o = ALU_SRA;
            end else begin
              illegal_enc = 1'b1;
            end
          end
        endcase
      end

      // Upper immediates, 0 + imm or pc + imm
      OPC_LUI, OPC_AUIPC: begin
        we_dec     = 1'b1;
        op_a_sel_o = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_U;
      end

      // Loads, address is rs1 + I immediate
      OPC_LOAD: begin
        we_dec          = 1'b1;
        req_dec         = 1'b1;
        rs1_used_dec    = 1'b1;
        op_b_sel_o      = OP_B_IMM;
        data_sign_ext_o = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: data_type_o = DT_BYTE;
          3'b001, 3'b101: data_type_o = DT_HALF;
          3'b010:         data_type_o = DT_WORD;
          default:        illegal_enc = 1'b1;
        endcase
      end

      // Stores, address is rs1 + S immediate, data from rs2
      OPC_STORE: begin
        req_dec      = 1'b1;
        dwe_dec      = 1'b1;
        rs1_used_dec = 1'b1;
        rs2_used_dec = 1'b1;
        op_b_sel_o   = OP_B_IMM;
        imm_sel_o    = IMM_S;
        case (funct3)
          3'b000:  data_type_o = DT_BYTE;
          3'b001:  data_type_o = DT_HALF;
          3'b010:  data_type_o = DT_WORD;
          default: illegal_enc = 1'b1;
        endcase
      end

      default: illegal_enc = 1'b1;
    endcase
  end

  // RV32E has x0..x15 only; check just the fields this encoding uses
  assign illegal_reg = (RV32E != 0) &&
                       ((rs1_used_dec && instr_i[19]) ||
                        (rs2_used_dec && instr_i[24]) ||
                        (we_dec && instr_i[11]));

  assign illegal_insn_o = illegal_enc | illegal_reg;

  // Illegal words have no side effects and no source dependencies
  assign regfile_we_o = we_dec & ~illegal_insn_o;
  assign data_req_o   = req_dec & ~illegal_insn_o;
  assign data_we_o    = dwe_dec & ~illegal_insn_o;
  assign rs1_used_o   = rs1_used_dec & ~illegal_insn_o;
  assign rs2_used_o   = rs2_used_dec & ~illegal_insn_o;

endmodule

`default_nettype wire

// ==== logic/id_operand_mux.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_operand_mux import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] rs1_data_i,
  input  logic [XLEN-1:0] rs2_data_i,
  input  op_a_sel_e       op_a_sel_i,
  input  op_b_sel_e       op_b_sel_i,
  input  imm_sel_e        imm_sel_i,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o
);

  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_b;

  //////////////////////////////////////////////////////////////////////
  // Immediate extraction
  //////////////////////////////////////////////////////////////////////

  // I-type, sign bit is instr[31]
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};

  // S-type, offset split around rd field
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

  // U-type, low 12 bits zero
  assign imm_u_type = {instr_i[31:12], 12'b0};

  always_comb begin
    case (imm_sel_i)
      IMM_I:   imm_b = imm_i_type;
      IMM_S:   imm_b = imm_s_type;
      IMM_U:   imm_b = imm_u_type;
      default: imm_b = imm_i_type;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand selection
  //////////////////////////////////////////////////////////////////////

  // Operand A
  always_comb begin
    case (op_a_sel_i)
      OP_A_REG:  alu_operand_a_o = rs1_data_i;
      OP_A_PC:   alu_operand_a_o = pc_i;
      OP_A_ZERO: alu_operand_a_o = '0;
      default:   alu_operand_a_o = rs1_data_i;
    endcase
  end

  // Operand B
  always_comb begin
    case (op_b_sel_i)
      OP_B_IMM: alu_operand_b_o = imm_b;
      default:  alu_operand_b_o = rs2_data_i;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/id_register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_register_file import id_pkg::*; #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] raddr_a_i,
  input  logic [ADDR_W-1:0] raddr_b_i,
  input  logic [ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  logic              we_i,
  output logic [XLEN-1:0]   rdata_a_o,
  output logic [XLEN-1:0]   rdata_b_o
);

  localparam int NUM_REGS = 2 ** ADDR_W;

  // x1 upwards, x0 is not stored
  logic [XLEN-1:0] mem [1:NUM_REGS-1];

  // Single write port, writes to x0 dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads, x0 hard-wired
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem[raddr_b_i];

endmodule

`default_nettype wire

// ==== logic/id_writeback_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_writeback_ctrl import id_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid_i,
  input  logic [REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [REG_ADDR_W-1:0] rs2_addr_i,
  input  logic [REG_ADDR_W-1:0] rd_addr_i,
  input  logic                  rs1_used_i,
  input  logic                  rs2_used_i,
  input  logic                  regfile_we_i,
  input  logic                  data_req_i,
  input  logic                  data_we_i,
  input  logic                  data_gnt_i,
  input  logic                  lsu_rvalid_i,
  input  logic [XLEN-1:0]       regfile_wdata_ex_i,
  input  logic [XLEN-1:0]       regfile_wdata_lsu_i,
  output logic                  id_ready_o,
  output logic                  id_valid_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  rf_we_o
);

  // Destination of the outstanding load, zero when none
  logic [REG_ADDR_W-1:0] pending_q;
  logic                  load_pending;
  logic                  is_load;
  logic                  lsu_wb;
  logic                  raw_hazard;
  logic                  load_stall;
  logic                  gnt_stall;
  logic                  ex_we;

  assign load_pending = (pending_q != '0);
  assign is_load      = data_req_i & ~data_we_i;

  // Load data returning owns the write port this cycle
  assign lsu_wb = lsu_rvalid_i & load_pending;

  //////////////////////////////////////////////////////////////////////
  // Stall generation
  //////////////////////////////////////////////////////////////////////

  // Read after load, only source fields actually read
  assign raw_hazard = load_pending &
                      ((rs1_used_i & (rs1_addr_i == pending_q)) |
                       (rs2_used_i & (rs2_addr_i == pending_q)));

  // Only one load in flight
  assign load_stall = load_pending & is_load;

  // LSU request waits for grant
  assign gnt_stall  = data_req_i & ~data_gnt_i;

  assign id_ready_o = ~(raw_hazard | load_stall | gnt_stall | lsu_wb);
  assign id_valid_o = instr_valid_i & id_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Write port arbitration
  //////////////////////////////////////////////////////////////////////

  // EX result of the instruction consumed now, loads excluded
  assign ex_we = id_valid_o & regfile_we_i & ~data_req_i & (rd_addr_i != '0);

  always_comb begin
    if (lsu_wb) begin
      rf_we_o    = 1'b1;
      rf_waddr_o = pending_q;
      rf_wdata_o = regfile_wdata_lsu_i;
    end else begin
      rf_we_o    = ex_we;
      rf_waddr_o = rd_addr_i;
      rf_wdata_o = regfile_wdata_ex_i;
    end
  end

  // Pending load register
  // Load to x0 leaves it at zero, its data is then ignored
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
    end else if (id_valid_o && is_load && regfile_we_i) begin
      pending_q <= rd_addr_i;
    end else if (lsu_wb) begin
      pending_q <= '0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_stage import id_pkg::*; #(
  parameter int RV32E = 0
) (
  input  logic            clk,
  input  logic            rst_n,

  // Fetch side
  input  logic            instr_valid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic [XLEN-1:0] pc_id_i,
  output logic            id_ready_o,
  output logic            id_valid_o,

  // EX side
  output logic            illegal_insn_o,
  output alu_op_e         alu_operator_o,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o,

  // LSU request
  input  logic            data_gnt_i,
  output logic            data_req_o,
  output logic            data_we_o,
  output data_type_e      data_type_o,
  output logic            data_sign_ext_o,
  output logic [XLEN-1:0] data_wdata_o,

  // Write-back
  input  logic            lsu_rvalid_i,
  input  logic [XLEN-1:0] regfile_wdata_ex_i,
  input  logic [XLEN-1:0] regfile_wdata_lsu_i
);

  // x0..x15 for RV32E, else x0..x31
  localparam int ADDR_W = (RV32E != 0) ? 4 : 5;

  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;

  op_a_sel_e             op_a_sel;
  op_b_sel_e             op_b_sel;
  imm_sel_e              imm_sel;
  logic                  regfile_we;
  logic                  rs1_used;
  logic                  rs2_used;
  logic                  dec_data_req;

  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  logic                  rf_we;

  // Fixed register fields
  assign rs1_addr = instr_rdata_i[19:15];
  assign rs2_addr = instr_rdata_i[24:20];
  assign rd_addr  = instr_rdata_i[11:7];

  //////////////////////////////////////////////////////////////////////
  // Decode and operands
  //////////////////////////////////////////////////////////////////////

  id_decoder #(
    .RV32E(RV32E)
  ) i_decoder (
    .instr_i        (instr_rdata_i),
    .alu_operator_o (alu_operator_o),
    .op_a_sel_o     (op_a_sel),
    .op_b_sel_o     (op_b_sel),
    .imm_sel_o      (imm_sel),
    .regfile_we_o   (regfile_we),
    .rs1_used_o     (rs1_used),
    .rs2_used_o     (rs2_used),
    .data_req_o     (dec_data_req),
    .data_we_o      (data_we_o),
    .data_type_o    (data_type_o),
    .data_sign_ext_o(data_sign_ext_o),
    .illegal_insn_o (illegal_insn_o)
  );

  id_operand_mux i_operand_mux (
    .instr_i        (instr_rdata_i),
    .pc_i           (pc_id_i),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .op_a_sel_i     (op_a_sel),
    .op_b_sel_i     (op_b_sel),
    .imm_sel_i      (imm_sel),
    .alu_operand_a_o(alu_operand_a_o),
    .alu_operand_b_o(alu_operand_b_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file and write-back
  //////////////////////////////////////////////////////////////////////

  // Upper address bit dropped for RV32E, decoder flags its use
  id_register_file #(
    .ADDR_W(ADDR_W)
  ) i_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .raddr_a_i(rs1_addr[ADDR_W-1:0]),
    .raddr_b_i(rs2_addr[ADDR_W-1:0]),
    .waddr_i  (rf_waddr[ADDR_W-1:0]),
    .wdata_i  (rf_wdata),
    .we_i     (rf_we),
    .rdata_a_o(rs1_data),
    .rdata_b_o(rs2_data)
  );

  id_writeback_ctrl i_writeback_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .instr_valid_i      (instr_valid_i),
    .rs1_addr_i         (rs1_addr),
    .rs2_addr_i         (rs2_addr),
    .rd_addr_i          (rd_addr),
    .rs1_used_i         (rs1_used),
    .rs2_used_i         (rs2_used),
    .regfile_we_i       (regfile_we),
    .data_req_i         (dec_data_req),
    .data_we_i          (data_we_o),
    .data_gnt_i         (data_gnt_i),
    .lsu_rvalid_i       (lsu_rvalid_i),
    .regfile_wdata_ex_i (regfile_wdata_ex_i),
    .regfile_wdata_lsu_i(regfile_wdata_lsu_i),
    .id_ready_o         (id_ready_o),
    .id_valid_o         (id_valid_o),
    .rf_waddr_o         (rf_waddr),
    .rf_wdata_o         (rf_wdata),
    .rf_we_o            (rf_we)
  );

  // LSU request only for a valid instruction, store data is rs2
  assign data_req_o   = dec_data_req & instr_valid_i;
  assign data_wdata_o = rs2_data;

endmodule

`default_nettype wire

// ==== testbench/id_stage_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module id_stage_assert import id_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  instr_valid_i,
  input logic [REG_ADDR_W-1:0] rs1_addr_i,
  input logic [REG_ADDR_W-1:0] rs2_addr_i,
  input logic                  rs1_used_i,
  input logic                  rs2_used_i,
  input logic                  data_req_i,
  input logic                  data_we_i,
  input logic                  data_gnt_i,
  input logic [REG_ADDR_W-1:0] pending_i,
  input logic                  id_ready_i,
  input logic                  id_valid_i,
  input logic                  rf_we_i,
  input logic [REG_ADDR_W-1:0] rf_waddr_i
);

  logic hazard;

  // Source reads the in-flight load target, or a second load
  assign hazard = (pending_i != '0) &&
                  ((rs1_used_i && (rs1_addr_i == pending_i)) ||
                   (rs2_used_i && (rs2_addr_i == pending_i)) ||
                   (data_req_i && !data_we_i));

  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    rf_we_i |-> (rf_waddr_i != '0))
    else $error("Register file write enabled for x0");

  valid_needs_instr: assert property (@(posedge clk) disable iff (!rst_n)
    id_valid_i |-> instr_valid_i)
    else $error("id_valid_o high without instr_valid_i");

  stall_on_hazard: assert property (@(posedge clk) disable iff (!rst_n)
    (hazard || (data_req_i && !data_gnt_i)) |-> !id_ready_i)
    else $error("id_ready_o high during hazard or missing grant");

endmodule

bind id_writeback_ctrl id_stage_assert i_stage_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .instr_valid_i(instr_valid_i),
  .rs1_addr_i   (rs1_addr_i),
  .rs2_addr_i   (rs2_addr_i),
  .rs1_used_i   (rs1_used_i),
  .rs2_used_i   (rs2_used_i),
  .data_req_i   (data_req_i),
  .data_we_i    (data_we_i),
  .data_gnt_i   (data_gnt_i),
  .pending_i    (pending_q),
  .id_ready_i   (id_ready_o),
  .id_valid_i   (id_valid_o),
  .rf_we_i      (rf_we_o),
  .rf_waddr_i   (rf_waddr_o)
);

`default_nettype wire

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  // Cycles one instruction may wait for id_ready_o
  localparam int WAIT_LIMIT = 200;
  localparam int NUM_INSTR  = 2000;

  logic            clk;
  logic            rst_n;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_rdata_i;
  logic [XLEN-1:0] pc_id_i;
  logic            data_gnt_i;
  logic            lsu_rvalid_i;
  logic [XLEN-1:0] regfile_wdata_ex_i;
  logic [XLEN-1:0] regfile_wdata_lsu_i;
  logic            id_ready_o;
  logic            id_valid_o;
  logic            illegal_insn_o;
  alu_op_e         alu_operator_o;
  logic [XLEN-1:0] alu_operand_a_o;
  logic [XLEN-1:0] alu_operand_b_o;
  logic            data_req_o;
  logic            data_we_o;
  data_type_e      data_type_o;
  logic            data_sign_ext_o;
  logic [XLEN-1:0] data_wdata_o;

  // Reference register file and outstanding load destination
  logic [XLEN-1:0] model_rf [32];
  logic [4:0]      model_pend;
  logic [31:0]     rng_state;

  // Expected decode of the word on the bus
  logic            exp_ill;
  logic            exp_we;
  logic            exp_u1;
  logic            exp_u2;
  logic            exp_req;
  logic            exp_st;
  logic            exp_sx;
  alu_op_e         exp_op;
  data_type_e      exp_dt;
  logic [XLEN-1:0] exp_a;
  logic [XLEN-1:0] exp_b;

  id_stage #(
    .RV32E(0)
  ) i_id_stage (
    .clk                (clk),
    .rst_n              (rst_n),
    .instr_valid_i      (instr_valid_i),
    .instr_rdata_i      (instr_rdata_i),
    .pc_id_i            (pc_id_i),
    .id_ready_o         (id_ready_o),
    .id_valid_o         (id_valid_o),
    .illegal_insn_o     (illegal_insn_o),
    .alu_operator_o     (alu_operator_o),
    .alu_operand_a_o    (alu_operand_a_o),
    .alu_operand_b_o    (alu_operand_b_o),
    .data_gnt_i         (data_gnt_i),
    .data_req_o         (data_req_o),
    .data_we_o          (data_we_o),
    .data_type_o        (data_type_o),
    .data_sign_ext_o    (data_sign_ext_o),
    .data_wdata_o       (data_wdata_o),
    .lsu_rvalid_i       (lsu_rvalid_i),
    .regfile_wdata_ex_i (regfile_wdata_ex_i),
    .regfile_wdata_lsu_i(regfile_wdata_lsu_i)
  );

  // 20 ns period
  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // 32-bit xorshift
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Mostly x0..x7 so hazards show up often
  function automatic logic [4:0] pick_reg(input logic [9:0] r);
    return (r[9:8] == 2'b00) ? r[4:0] : {2'b00, r[2:0]};
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Weighted mix of the decoded groups plus raw random words
  function automatic logic [31:0] gen_instr();
    logic [31:0] r;
    logic [31:0] f;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    r    = next_random();
    f    = next_random();
    kind = r[3:0];
    f3   = f[14:12];
    imm  = f[31:20];
    if (kind <= 4) begin
      f7 = (r[5:4] == 2'b00) ? 7'h20 : 7'h00;
      // Occasional junk funct7
      if (r[11:8] == 4'h0) begin
        f7 = f[31:25];
      end
      return {f7, pick_reg(r[21:12]), pick_reg(r[31:22]), f3, pick_reg(f[9:0]), OPC_OP};
    end else if (kind <= 8) begin
      // Shift amounts carry funct7 in imm[11:5]
      if (f3[1:0] == 2'b01) begin
        imm[11:5] = r[6] ? 7'h20 : 7'h00;
      end
      return {imm, pick_reg(r[31:22]), f3, pick_reg(f[9:0]), OPC_OP_IMM};
    end else if (kind == 9) begin
      return {f[31:12], pick_reg(r[21:12]), OPC_LUI};
    end else if (kind == 10) begin
      return {f[31:12], pick_reg(r[21:12]), OPC_AUIPC};
    end else if (kind <= 12) begin
      if ((f3 == 3'd3) || (f3 >= 3'd6)) begin
        f3 = 3'd2;
      end
      return {imm, pick_reg(r[31:22]), f3, pick_reg(f[9:0]), OPC_LOAD};
    end else if (kind <= 14) begin
      f3 = {1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0]};
      return {imm[11:5], pick_reg(r[21:12]), pick_reg(r[31:22]), f3, imm[4:0], OPC_STORE};
    end
    return f;
  endfunction

  function automatic alu_op_e alu_for_funct3(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference decode from the RV32I encoding
  //////////////////////////////////////////////////////////////////////

  task automatic decode_ref(input logic [31:0] w, input logic [31:0] pc);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_u;
    f3      = w[14:12];
    f7      = w[31:25];
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_u   = {w[31:12], 12'b0};
    exp_ill = 1'b0;
    exp_we  = 1'b0;
    exp_u1  = 1'b0;
    exp_u2  = 1'b0;
    exp_req = 1'b0;
    exp_st  = 1'b0;
    exp_sx  = 1'b0;
    exp_op  = ALU_ADD;
    exp_dt  = DT_WORD;
    exp_a   = model_rf[w[19:15]];
    exp_b   = model_rf[w[24:20]];
    case (w[6:0])
      OPC_OP: begin
        exp_we = 1'b1;
        exp_u1 = 1'b1;
        exp_u2 = 1'b1;
        if ((f7 == 7'h20) && (f3 == 3'd0)) begin
          exp_op = ALU_SUB;
        end else if ((f7 == 7'h20) && (f3 == 3'd5)) begin
          exp_op = ALU_SRA;
        end else if (f7 == 7'h00) begin
          exp_op = alu_for_funct3(f3);
        end else begin
          exp_ill = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        exp_we = 1'b1;
        exp_u1 = 1'b1;
        exp_b  = imm_i;
        exp_op = alu_for_funct3(f3);
        if (f3 == 3'd1) begin
          exp_ill = (f7 != 7'h00);
        end else if (f3 == 3'd5) begin
          if (f7 == 7'h20) begin
            exp_op = ALU_SRA;
          end else if (f7 != 7'h00) begin
            exp_ill = 1'b1;
          end
        end
      end
      OPC_LUI, OPC_AUIPC: begin
        exp_we = 1'b1;
        exp_a  = (w[6:0] == OPC_LUI) ? 32'h0 : pc;
        exp_b  = imm_u;
      end
      OPC_LOAD: begin
        exp_we  = 1'b1;
        exp_u1  = 1'b1;
        exp_req = 1'b1;
        exp_b   = imm_i;
        exp_sx  = ~f3[2];
        case (f3)
          3'd0, 3'd4: exp_dt = DT_BYTE;
          3'd1, 3'd5: exp_dt = DT_HALF;
          3'd2:       exp_dt = DT_WORD;
          default:    exp_ill = 1'b1;
        endcase
      end
      OPC_STORE: begin
        exp_u1  = 1'b1;
        exp_u2  = 1'b1;
        exp_req = 1'b1;
        exp_st  = 1'b1;
        exp_b   = imm_s;
        case (f3)
          3'd0:    exp_dt = DT_BYTE;
          3'd1:    exp_dt = DT_HALF;
          3'd2:    exp_dt = DT_WORD;
          default: exp_ill = 1'b1;
        endcase
      end
      default: exp_ill = 1'b1;
    endcase
    // Illegal words have no effects and read nothing
    if (exp_ill) begin
      exp_we  = 1'b0;
      exp_req = 1'b0;
      exp_st  = 1'b0;
      exp_u1  = 1'b0;
      exp_u2  = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One clock cycle: drive, check at negedge, advance the model
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle(input logic v, input logic [31:0] w, input logic [31:0] pc,
                            output logic taken);
    logic [4:0] rd;
    logic       pend;
    logic       lsu_wb;
    logic       hazard;
    logic       ready;
    rd = w[11:7];
    @(posedge clk);
    instr_valid_i       <= v;
    instr_rdata_i       <= w;
    pc_id_i             <= pc;
    data_gnt_i          <= (next_random() % 4) != 0;
    // Load data only returns while a load is in flight
    lsu_rvalid_i        <= (model_pend != 5'd0) && ((next_random() % 3) == 0);
    regfile_wdata_ex_i  <= next_random();
    regfile_wdata_lsu_i <= next_random();
    @(negedge clk);
    decode_ref(w, pc);
    pend   = (model_pend != 5'd0);
    lsu_wb = lsu_rvalid_i && pend;
    hazard = pend && ((exp_u1 && (w[19:15] == model_pend)) ||
                      (exp_u2 && (w[24:20] == model_pend)));
    ready  = !(lsu_wb || hazard || (pend && exp_req && !exp_st) ||
               (exp_req && !data_gnt_i));
    check_value(id_ready_o, ready, "id_ready_o");
    check_value(id_valid_o, v && ready, "id_valid_o");
    check_value(data_req_o, v && exp_req, "data_req_o");
    if (v) begin
      check_value(illegal_insn_o, exp_ill, "illegal_insn_o");
      if (!exp_ill) begin
        check_value(alu_operator_o, exp_op, "alu_operator_o");
        check_value(alu_operand_a_o, exp_a, "alu_operand_a_o");
        check_value(alu_operand_b_o, exp_b, "alu_operand_b_o");
        if (exp_req) begin
          check_value(data_we_o, exp_st, "data_we_o");
          check_value(data_type_o, exp_dt, "data_type_o");
          check_value(data_sign_ext_o, exp_sx, "data_sign_ext_o");
          check_value(data_wdata_o, model_rf[w[24:20]], "data_wdata_o");
        end
      end
    end
    // Model state as it will be after the next rising edge
    if (lsu_wb) begin
      model_rf[model_pend] = regfile_wdata_lsu_i;
      model_pend           = 5'd0;
    end else if (v && ready && exp_we) begin
      if (exp_req) begin
        model_pend = rd;
      end else if (rd != 5'd0) begin
        model_rf[rd] = regfile_wdata_ex_i;
      end
    end
    taken = v && ready;
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] pc;
    logic        taken;
    int          waited;
    rng_state           = 32'd50;
    clk                 = 1'b0;
    rst_n               = 1'b0;
    instr_valid_i       = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    data_gnt_i          = 1'b0;
    lsu_rvalid_i        = 1'b0;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    model_pend          = 5'd0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    for (int n = 0; n < NUM_INSTR; n++) begin
      word = gen_instr();
      pc   = next_random() & 32'hFFFF_FFFC;
      // Occasional bubble with the word already on the bus
      if ((next_random() % 8) == 0) begin
        step_cycle(1'b0, word, pc, taken);
      end
      taken  = 1'b0;
      waited = 0;
      while (!taken) begin
        if (waited == WAIT_LIMIT) begin
          $display("Instruction %0d was not accepted within %0d cycles", n, WAIT_LIMIT);
          $display("ERRORS FOUND");
          $fatal(1, "Timeout waiting for id_ready_o");
        end
        step_cycle(1'b1, word, pc, taken);
        waited++;
      end
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
logic/id_pkg.sv
logic/id_decoder.sv
logic/id_operand_mux.sv
logic/id_register_file.sv
logic/id_writeback_ctrl.sv
logic/id_stage.sv
testbench/id_stage_assert.sv
testbench/tb_id_stage.sv

// ==== Makefile ====
# Verilator build and run of the decode stage testbench

SOURCES := files.f $(wildcard logic/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_id_stage: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_id_stage -f files.f -o Vtb_id_stage

# Exit status of the simulator is the test result
run: obj_dir/Vtb_id_stage
	./obj_dir/Vtb_id_stage

clean:
	rm -rf obj_dir
